// ==== include/combiner_consts.svh ====
`ifndef COMBINER_CONSTS_SVH
`define COMBINER_CONSTS_SVH

// datapath widths.
`define SAMPLE_W 18
`define AGC_W 12
`define DWELL_W 10

// word addresses on the register bus.
`define REG_CONTROL 2'd0
`define REG_DWELL 2'd1
`define REG_THRESH 2'd2
`define REG_STATUS 2'd3

// bit positions inside CONTROL and STATUS.
`define CTRL_ENABLE 0
`define CTRL_SELECT 1
`define STAT_LOCKED 0
`define STAT_QUAD_LO 1
`define STAT_QUAD_HI 2
`define STAT_AGC_GT 3

// values loaded at reset.
`define DWELL_DEFAULT 64
`define THRESH_DEFAULT 56

`endif

// ==== design/combinerPkg.sv ====
`default_nettype none

`include "combiner_consts.svh"

package combinerPkg;

    // one signed real or imaginary component.
    typedef logic signed [`SAMPLE_W-1:0] sampleT;

    // agc gain word, a larger value means a weaker channel.
    typedef logic [`AGC_W-1:0] agcT;

    // channel 2 rotation in quarter turns.
    typedef logic [1:0] quadT;

    // dwell length, lock threshold and agreement count.
    typedef logic [`DWELL_W-1:0] dwellT;

    // register bus word address and data word.
    typedef logic [1:0] regAddrT;
    typedef logic [31:0] wordT;

    // lock search states.
    typedef enum logic [1:0] {
        IDLE,
        SEARCH,
        TRACK
    } lockStateT;

endpackage

`default_nettype wire

// ==== design/pairedSampleIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// channel 1 and channel 2 complex samples moving together.
interface pairedSampleIf;

    combinerPkg::sampleT ch1Re;
    combinerPkg::sampleT ch1Im;
    combinerPkg::sampleT ch2Re;
    combinerPkg::sampleT ch2Im;
    logic valid;

    modport source (
        output ch1Re,
        output ch1Im,
        output ch2Re,
        output ch2Im,
        output valid
    );

    modport sink (
        input ch1Re,
        input ch1Im,
        input ch2Re,
        input ch2Im,
        input valid
    );

endinterface

`default_nettype wire

// ==== design/combinerRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "combiner_consts.svh"

module combinerRegs (
    input  logic                clk,
    input  logic                arstN,
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  combinerPkg::regAddrT wbAdr,
    input  combinerPkg::wordT   wbDatW,
    output combinerPkg::wordT   wbDatR,
    output logic                wbAck,
    output logic                enable,
    output logic                selectMode,
    output combinerPkg::dwellT  dwellLen,
    output combinerPkg::dwellT  lockThresh,
    input  logic                locked,
    input  combinerPkg::quadT   quadrant,
    input  logic                agc1GtAgc2
);

    logic accept;
    combinerPkg::wordT readWord;

    // a request is taken only when the previous cycle did not acknowledge.
    assign accept = wbCyc && wbStb && !wbAck;

    always_comb begin
        readWord = '0;
        case (wbAdr)
            `REG_CONTROL: begin
                readWord[`CTRL_ENABLE] = enable;
                readWord[`CTRL_SELECT] = selectMode;
            end
            `REG_DWELL:  readWord = combinerPkg::wordT'(dwellLen);
            `REG_THRESH: readWord = combinerPkg::wordT'(lockThresh);
            default: begin
                // status is assembled from live signals.
                readWord[`STAT_LOCKED] = locked;
                readWord[`STAT_QUAD_HI:`STAT_QUAD_LO] = quadrant;
                readWord[`STAT_AGC_GT] = agc1GtAgc2;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck      <= 1'b0;
            enable     <= 1'b0;
            selectMode <= 1'b0;
            dwellLen   <= combinerPkg::dwellT'(`DWELL_DEFAULT);
            lockThresh <= combinerPkg::dwellT'(`THRESH_DEFAULT);
        end else begin
            wbAck <= accept;
            if (accept && wbWe) begin
                case (wbAdr)
                    `REG_CONTROL: begin
                        enable     <= wbDatW[`CTRL_ENABLE];
                        selectMode <= wbDatW[`CTRL_SELECT];
                    end
                    `REG_DWELL:  dwellLen <= wbDatW[`DWELL_W-1:0];
                    `REG_THRESH: lockThresh <= wbDatW[`DWELL_W-1:0];
                    // status is read only.
                    default: ;
                endcase
            end
        end
    end

    // read data is captured together with the acknowledge.
    always_ff @(posedge clk) begin
        if (accept) begin
            wbDatR <= readWord;
        end
    end

    ackOneCycle: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck)
        else $error("wbAck held high for two cycles");

endmodule

`default_nettype wire

// ==== design/quadrantAligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module quadrantAligner (
    input  logic               clk,
    input  logic               arstN,
    pairedSampleIf.sink        raw,
    pairedSampleIf.source      aligned,
    input  combinerPkg::quadT  quadrant,
    input  logic               restartDwell,
    output combinerPkg::dwellT agreeCount
);

    combinerPkg::sampleT rotRe;
    combinerPkg::sampleT rotIm;
    combinerPkg::dwellT agreeReg;
    logic agreeNow;

    // negate with the most negative code clipped to the most positive one.
    function automatic combinerPkg::sampleT satNeg(input combinerPkg::sampleT x);
        combinerPkg::sampleT minVal;
        minVal = '0;
        minVal[$bits(minVal)-1] = 1'b1;
        return (x == minVal) ? ~x : -x;
    endfunction

    always_comb begin
        case (quadrant)
            2'd1: begin
                rotRe = raw.ch2Im;
                rotIm = satNeg(raw.ch2Re);
            end
            2'd2: begin
                rotRe = satNeg(raw.ch2Re);
                rotIm = satNeg(raw.ch2Im);
            end
            2'd3: begin
                rotRe = satNeg(raw.ch2Im);
                rotIm = raw.ch2Re;
            end
            default: begin
                rotRe = raw.ch2Re;
                rotIm = raw.ch2Im;
            end
        endcase
    end

    // both sign bits must match for a sample to agree.
    assign agreeNow = raw.valid && ((raw.ch1Re < 0) == (rotRe < 0))
                                && ((raw.ch1Im < 0) == (rotIm < 0));

    // the current sample is included so the window end sees its full count.
    assign agreeCount = (agreeReg == '1) ? agreeReg
                                         : agreeReg + combinerPkg::dwellT'(agreeNow);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            agreeReg      <= '0;
            aligned.valid <= 1'b0;
        end else begin
            agreeReg      <= restartDwell ? '0 : agreeCount;
            aligned.valid <= raw.valid;
        end
    end

    always_ff @(posedge clk) begin
        aligned.ch1Re <= raw.ch1Re;
        aligned.ch1Im <= raw.ch1Im;
        aligned.ch2Re <= rotRe;
        aligned.ch2Im <= rotIm;
    end

endmodule

`default_nettype wire

// ==== design/dwellTimer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dwellTimer (
    input  logic               clk,
    input  logic               arstN,
    input  logic               sampleValid,
    input  logic               restartDwell,
    input  combinerPkg::dwellT dwellLen,
    output logic               dwellDone
);

    combinerPkg::dwellT validCount;

    // the window ends on the dwellLen-th valid sample.
    assign dwellDone = sampleValid && (combinerPkg::dwellT'(validCount + 1'b1) == dwellLen);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validCount <= '0;
        end else if (restartDwell || dwellDone) begin
            validCount <= '0;
        end else if (sampleValid) begin
            validCount <= validCount + 1'b1;
        end
    end

    doneNeedsSample: assert property (@(posedge clk) disable iff (!arstN)
        dwellDone |-> sampleValid)
        else $error("dwellDone without a valid sample");

endmodule

`default_nettype wire

// ==== design/lockController.sv ====
`timescale 1ns/1ps
`default_nettype none

module lockController (
    input  logic               clk,
    input  logic               arstN,
    input  logic               enable,
    input  logic               dwellDone,
    input  combinerPkg::dwellT agreeCount,
    input  combinerPkg::dwellT lockThresh,
    output combinerPkg::quadT  quadrant,
    output logic               restartDwell,
    output logic               locked
);

    combinerPkg::lockStateT state;

    // the timer is held clear while idle and restarts at every window end.
    assign restartDwell = !enable || (state == combinerPkg::IDLE) || dwellDone;

    assign locked = (state == combinerPkg::TRACK);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= combinerPkg::IDLE;
            quadrant <= '0;
        end else if (!enable) begin
            state    <= combinerPkg::IDLE;
            quadrant <= '0;
        end else begin
            case (state)
                combinerPkg::IDLE: begin
                    state <= combinerPkg::SEARCH;
                end
                combinerPkg::SEARCH: begin
                    if (dwellDone) begin
                        if (agreeCount >= lockThresh) begin
                            state <= combinerPkg::TRACK;
                        end else begin
                            // try the next quarter turn.
                            quadrant <= quadrant + 1'b1;
                        end
                    end
                end
                combinerPkg::TRACK: begin
                    // lost agreement, search again from the same quadrant.
                    if (dwellDone && (agreeCount < lockThresh)) begin
                        state <= combinerPkg::SEARCH;
                    end
                end
                default: begin
                    state <= combinerPkg::IDLE;
                end
            endcase
        end
    end

    quadWithRestart: assert property (@(posedge clk) disable iff (!arstN)
        !restartDwell |=> $stable(quadrant))
        else $error("quadrant changed without a dwell restart");

endmodule

`default_nettype wire

// ==== design/diversityCombiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module diversityCombiner (
    input  logic                clk,
    input  logic                arstN,
    pairedSampleIf.sink         aligned,
    input  combinerPkg::agcT    ch1Agc,
    input  combinerPkg::agcT    ch2Agc,
    input  logic                selectMode,
    output combinerPkg::sampleT outRe,
    output combinerPkg::sampleT outIm,
    output logic                outValid,
    output logic                agc1GtAgc2
);

    localparam int SW = $bits(combinerPkg::sampleT);

    logic signed [SW:0] sumRe;
    logic signed [SW:0] sumIm;
    logic agcGt;

    // one extra bit keeps the full sum before halving.
    assign sumRe = aligned.ch1Re + aligned.ch2Re;
    assign sumIm = aligned.ch1Im + aligned.ch2Im;

    // larger agc means channel 1 is the weaker one.
    assign agcGt = ch1Agc > ch2Agc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid   <= 1'b0;
            agc1GtAgc2 <= 1'b0;
        end else begin
            outValid   <= aligned.valid;
            agc1GtAgc2 <= agcGt;
        end
    end

    always_ff @(posedge clk) begin
        if (!selectMode) begin
            // dropping the low bit is a floor divide by two.
            outRe <= sumRe[SW:1];
            outIm <= sumIm[SW:1];
        end else if (agcGt) begin
            outRe <= aligned.ch2Re;
            outIm <= aligned.ch2Im;
        end else begin
            outRe <= aligned.ch1Re;
            outIm <= aligned.ch1Im;
        end
    end

endmodule

`default_nettype wire

// ==== design/combinerTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module combinerTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  combinerPkg::regAddrT wbAdr,
    input  combinerPkg::wordT    wbDatW,
    output combinerPkg::wordT    wbDatR,
    output logic                 wbAck,
    input  combinerPkg::sampleT  ch1Re,
    input  combinerPkg::sampleT  ch1Im,
    input  combinerPkg::sampleT  ch2Re,
    input  combinerPkg::sampleT  ch2Im,
    input  combinerPkg::agcT     ch1Agc,
    input  combinerPkg::agcT     ch2Agc,
    input  logic                 sampleValid,
    output combinerPkg::sampleT  outRe,
    output combinerPkg::sampleT  outIm,
    output logic                 outValid,
    output logic                 locked
);

    logic enable;
    logic selectMode;
    logic agc1GtAgc2;
    logic restartDwell;
    logic dwellDone;
    combinerPkg::dwellT dwellLen;
    combinerPkg::dwellT lockThresh;
    combinerPkg::dwellT agreeCount;
    combinerPkg::quadT quadrant;

    pairedSampleIf raw ();
    pairedSampleIf aligned ();

    assign raw.ch1Re = ch1Re;
    assign raw.ch1Im = ch1Im;
    assign raw.ch2Re = ch2Re;
    assign raw.ch2Im = ch2Im;
    assign raw.valid = sampleValid;

    combinerRegs regs (
        .clk, .arstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
        .enable, .selectMode, .dwellLen, .lockThresh, .locked, .quadrant, .agc1GtAgc2
    );

    quadrantAligner aligner (
        .clk, .arstN, .raw(raw.sink), .aligned(aligned.source),
        .quadrant, .restartDwell, .agreeCount
    );

    // the dwell window counts raw input samples.
    dwellTimer timer (
        .clk, .arstN, .sampleValid, .restartDwell, .dwellLen, .dwellDone
    );

    lockController lockCtrl (
        .clk, .arstN, .enable, .dwellDone, .agreeCount, .lockThresh,
        .quadrant, .restartDwell, .locked
    );

    diversityCombiner combiner (
        .clk, .arstN, .aligned(aligned.sink), .ch1Agc, .ch2Agc, .selectMode,
        .outRe, .outIm, .outValid, .agc1GtAgc2
    );

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// free running 8 ns clock and a reset held low for five cycles.
module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release away from the rising edge.
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/combinerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "combiner_consts.svh"

module combinerTb;

    localparam int TEST_COUNT = 6;
    localparam int CYCLE_LIMIT = `DWELL_DEFAULT * 4 * TEST_COUNT + 1000;
    localparam int LOCK_LIMIT = 4 * `DWELL_DEFAULT + 4;
    localparam combinerPkg::sampleT SAMPLE_MIN = {1'b1, {(`SAMPLE_W-1){1'b0}}};
    localparam combinerPkg::sampleT SAMPLE_MAX = ~SAMPLE_MIN;

    logic clk;
    logic arstN;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    combinerPkg::regAddrT wbAdr;
    combinerPkg::wordT wbDatW;
    combinerPkg::wordT wbDatR;
    logic wbAck;
    combinerPkg::sampleT ch1Re;
    combinerPkg::sampleT ch1Im;
    combinerPkg::sampleT ch2Re;
    combinerPkg::sampleT ch2Im;
    combinerPkg::agcT ch1Agc;
    combinerPkg::agcT ch2Agc;
    logic sampleValid;
    combinerPkg::sampleT outRe;
    combinerPkg::sampleT outIm;
    logic outValid;
    logic locked;

    // stream control and model state.
    logic streaming;
    logic indepCh2;
    logic checkOut;
    logic modelSelect;
    combinerPkg::quadT offset;
    combinerPkg::quadT modelQuad;
    logic [31:0] lfsrState;
    combinerPkg::sampleT s1Ch1Re;
    combinerPkg::sampleT s1Ch1Im;
    combinerPkg::sampleT s1Ch2Re;
    combinerPkg::sampleT s1Ch2Im;
    combinerPkg::sampleT expRe;
    combinerPkg::sampleT expIm;
    int errCount;
    int testStart;
    int testsRun;
    int testsFailed;
    int cycleCount;

    clockGen clocks (.clk, .arstN);

    combinerTop DUT (.*);

    // galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic combinerPkg::sampleT negSat(input combinerPkg::sampleT x);
        return (x == SAMPLE_MIN) ? SAMPLE_MAX : -x;
    endfunction

    // quarter turn rule, (re, im) becomes (im, -re) per step.
    function automatic logic [2*`SAMPLE_W-1:0] rotate(input combinerPkg::sampleT re,
                                                      input combinerPkg::sampleT im,
                                                      input combinerPkg::quadT q);
        case (q)
            2'd1: return {im, negSat(re)};
            2'd2: return {negSat(re), negSat(im)};
            2'd3: return {negSat(im), re};
            default: return {re, im};
        endcase
    endfunction

    function automatic combinerPkg::sampleT halfSum(input combinerPkg::sampleT a,
                                                    input combinerPkg::sampleT b);
        logic signed [`SAMPLE_W:0] sum;
        logic signed [`SAMPLE_W:0] shifted;
        sum = {a[`SAMPLE_W-1], a} + {b[`SAMPLE_W-1], b};
        shifted = sum >>> 1;
        return shifted[`SAMPLE_W-1:0];
    endfunction

    // 17 random bits, sign extended, so negation never clips.
    task automatic drawSample(output combinerPkg::sampleT s);
        logic [`SAMPLE_W-2:0] bits;
        for (int i = 0; i < `SAMPLE_W - 1; i++) begin
            lfsrState = nextLfsr(lfsrState);
            bits[i] = lfsrState[0];
        end
        s = {bits[`SAMPLE_W-2], bits};
    endtask

    task automatic busAccess(input combinerPkg::regAddrT adr, input logic we,
                             input combinerPkg::wordT datW, output combinerPkg::wordT datR);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatW = datW;
        @(negedge clk);
        while (!wbAck) @(negedge clk);
        datR = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic writeReg(input combinerPkg::regAddrT adr, input combinerPkg::wordT data);
        combinerPkg::wordT unused;
        busAccess(adr, 1'b1, data, unused);
    endtask

    task automatic readReg(input combinerPkg::regAddrT adr, output combinerPkg::wordT data);
        busAccess(adr, 1'b0, '0, data);
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic waitLockLevel(input logic level, output int cycles);
        cycles = 0;
        while (locked != level) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic checkValue(input combinerPkg::wordT got, input combinerPkg::wordT exp,
                              input string what);
        assert (got == exp) else begin
            errCount++;
            $display("[FAIL] %0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (errCount != testStart) begin
            testsFailed++;
            $display("test %0d %s: failed", testsRun, name);
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
        testStart = errCount;
    endtask

    // channel 2 is a half scale copy of channel 1 turned by the offset unless it runs free.
    always @(negedge clk) begin
        if (streaming) begin
            drawSample(ch1Re);
            drawSample(ch1Im);
            if (indepCh2) begin
                drawSample(ch2Re);
                drawSample(ch2Im);
            end else begin
                {ch2Re, ch2Im} = rotate(ch1Re >>> 1, ch1Im >>> 1, offset);
            end
            sampleValid = 1'b1;
        end else begin
            sampleValid = 1'b0;
        end
    end

    // two stage reference pipeline.
    always @(posedge clk) begin
        s1Ch1Re <= ch1Re;
        s1Ch1Im <= ch1Im;
        {s1Ch2Re, s1Ch2Im} <= rotate(ch2Re, ch2Im, modelQuad);
        if (!modelSelect) begin
            expRe <= halfSum(s1Ch1Re, s1Ch2Re);
            expIm <= halfSum(s1Ch1Im, s1Ch2Im);
        end else if (ch1Agc > ch2Agc) begin
            expRe <= s1Ch2Re;
            expIm <= s1Ch2Im;
        end else begin
            expRe <= s1Ch1Re;
            expIm <= s1Ch1Im;
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ackFollowsRequest: assert property (@(posedge clk) disable iff (!arstN)
        (wbCyc && wbStb && !wbAck) |=> wbAck)
        else begin
            errCount++;
            $display("[FAIL] %0t bus request was not acknowledged next cycle", $time);
        end

    ackSingleCycle: assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck)
        else begin
            errCount++;
            $display("[FAIL] %0t wbAck stayed high for a second cycle", $time);
        end

    outLatency: assert property (@(posedge clk) disable iff (!arstN)
        outValid == $past(sampleValid, 2))
        else begin
            errCount++;
            $display("[FAIL] %0t outValid is not sampleValid delayed by 2", $time);
        end

    outMatchesModel: assert property (@(posedge clk) disable iff (!arstN)
        (checkOut && outValid) |-> (outRe == expRe && outIm == expIm))
        else begin
            errCount++;
            $display("[FAIL] %0t output %0d,%0d expected %0d,%0d", $time,
                     $sampled(outRe), $sampled(outIm), $sampled(expRe), $sampled(expIm));
        end

    initial begin
        combinerPkg::wordT rd;
        combinerPkg::quadT lostQuad;
        int cycles;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        ch1Re = '0;
        ch1Im = '0;
        ch2Re = '0;
        ch2Im = '0;
        ch1Agc = 12'd500;
        ch2Agc = 12'd500;
        sampleValid = 1'b0;
        streaming = 1'b0;
        indepCh2 = 1'b0;
        checkOut = 1'b0;
        modelSelect = 1'b0;
        offset = '0;
        modelQuad = '0;
        lfsrState = 32'h991315f3;
        errCount = 0;
        testStart = 0;
        testsRun = 0;
        testsFailed = 0;
        cycleCount = 0;
        @(posedge arstN);
        @(negedge clk);

        readReg(`REG_CONTROL, rd);
        checkValue(rd, 0, "CONTROL after reset");
        readReg(`REG_DWELL, rd);
        checkValue(rd, `DWELL_DEFAULT, "DWELL after reset");
        readReg(`REG_THRESH, rd);
        checkValue(rd, `THRESH_DEFAULT, "THRESH after reset");
        readReg(`REG_STATUS, rd);
        checkValue(rd, 0, "STATUS after reset");
        finishTest("register reset values");

        // the lock quadrant must undo each offset.
        streaming = 1'b1;
        for (int k = 0; k < 4; k++) begin
            writeReg(`REG_CONTROL, 32'd0);
            offset = 2'(k);
            writeReg(`REG_CONTROL, 32'd1);
            waitLockLevel(1'b1, cycles);
            checkValue(combinerPkg::wordT'(cycles <= LOCK_LIMIT), 1, "lock within four dwells");
            readReg(`REG_STATUS, rd);
            checkValue(combinerPkg::wordT'(rd[0]), 1, "STATUS locked");
            checkValue(combinerPkg::wordT'(rd[2:1]),
                       combinerPkg::wordT'(combinerPkg::quadT'(-offset)),
                       "STATUS quadrant");
        end
        finishTest("lock on each offset");

        modelQuad = -offset;
        waitCycles(3);
        checkOut = 1'b1;
        waitCycles(`DWELL_DEFAULT);
        checkOut = 1'b0;
        finishTest("sum combining");

        ch1Agc = 12'd900;
        ch2Agc = 12'd300;
        writeReg(`REG_CONTROL, 32'd3);
        modelSelect = 1'b1;
        waitCycles(3);
        checkOut = 1'b1;
        waitCycles(32);
        checkOut = 1'b0;
        readReg(`REG_STATUS, rd);
        checkValue(combinerPkg::wordT'(rd[3]), 1, "STATUS agc1GtAgc2 set");
        ch1Agc = 12'd300;
        ch2Agc = 12'd900;
        waitCycles(3);
        checkOut = 1'b1;
        waitCycles(32);
        checkOut = 1'b0;
        readReg(`REG_STATUS, rd);
        checkValue(combinerPkg::wordT'(rd[3]), 0, "STATUS agc1GtAgc2 clear");
        finishTest("selection combining");

        // a free running channel 2 has no quadrant that agrees.
        lostQuad = modelQuad;
        indepCh2 = 1'b1;
        waitLockLevel(1'b0, cycles);
        checkValue(combinerPkg::wordT'(cycles <= 2 * `DWELL_DEFAULT + 4), 1,
                   "lock lost within two dwells");
        readReg(`REG_STATUS, rd);
        checkValue(combinerPkg::wordT'(rd[2:0]), combinerPkg::wordT'({lostQuad, 1'b0}),
                   "STATUS after lock loss");
        waitCycles(`DWELL_DEFAULT);
        readReg(`REG_STATUS, rd);
        checkValue(combinerPkg::wordT'(rd[2:1]),
                   combinerPkg::wordT'(combinerPkg::quadT'(lostQuad + 2'd1)),
                   "search stepped the quadrant");
        finishTest("loss of lock");

        writeReg(`REG_CONTROL, 32'd0);
        waitCycles(2);
        checkValue(combinerPkg::wordT'(locked), 0, "locked after disable");
        readReg(`REG_STATUS, rd);
        checkValue(combinerPkg::wordT'(rd[2:0]), 0, "STATUS after disable");
        streaming = 1'b0;
        finishTest("disable");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== combiner.f ====
+incdir+include
design/combinerPkg.sv
design/pairedSampleIf.sv
design/combinerRegs.sv
design/quadrantAligner.sv
design/dwellTimer.sv
design/lockController.sv
design/diversityCombiner.sv
design/combinerTop.sv
bench/clockGen.sv
bench/combinerTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the combiner testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module combinerTb \
        -f combiner.f -o combinerSim; then
    echo "verilator build failed"
    exit 1
fi

if ! simOut=$(./obj_dir/combinerSim); then
    echo "$simOut"
    echo "simulation ended with an error status"
    exit 1
fi

echo "$simOut"
if echo "$simOut" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
